// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert
TOP      ?= tb_apu
FILELIST ?= apu.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

SRCS := $(shell grep -v '^+' $(FILELIST)) apu_consts.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Result: PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: apu.f
+incdir+.
apu_pkg.sv
apu_clock_gen.sv
apu_control.sv
apu_tone_chan.sv
apu_mixer.sv
apu_top.sv
tb_apu.sv

// File: apu_clock_gen.sv
`timescale 1ns/1ns
`include "apu_consts.svh"

module apu_clock_gen
	import apu_pkg::*;
(
	input  logic  apuv_4mhz,
	input  logic  rst_n,
	input  logic  frame_tick,
	input  logic  test_mode,
	output logic  en_2mhz,
	output logic  en_1mhz,
	output logic  len_tick,
	output step_t frame_step
);

	localparam int FAST_W = $clog2(`APU_FAST_DIV);

	logic [1:0] div;
	logic [FAST_W-1:0] fast_cnt;
	logic fast_tick;
	logic seq_tick;

	// 4 MHz down to 2 and 1 MHz enables.
	always_ff @(posedge apuv_4mhz) begin
		if (!rst_n) begin
			div <= '0;
		end else begin
			div <= div + 2'd1;
		end
	end

	assign en_2mhz = div[0];
	assign en_1mhz = &div; // one in four.

	// fast frame tick for test mode.
	always_ff @(posedge apuv_4mhz) begin
		if (!rst_n || fast_tick) begin
			fast_cnt <= '0;
		end else begin
			fast_cnt <= fast_cnt + FAST_W'(1);
		end
	end

	assign fast_tick = (fast_cnt == FAST_W'(`APU_FAST_DIV - 1));
	assign seq_tick  = test_mode ? fast_tick : frame_tick;

	// length clock on every even step.
	always_ff @(posedge apuv_4mhz) begin
		if (!rst_n) begin
			frame_step <= '0;
			len_tick   <= 1'b0;
		end else begin
			len_tick <= seq_tick && !frame_step[0];
			if (seq_tick) begin
				frame_step <= frame_step + step_t'(1);
			end
		end
	end

endmodule

// File: apu_consts.svh
`ifndef APU_CONSTS_SVH
`define APU_CONSTS_SVH

// master registers, low address byte.
`define APU_NR50 8'h24 // master volume and external input enables.
`define APU_NR51 8'h25 // channel panning.
`define APU_NR52 8'h26 // power and channel status.

// channel register bases, four registers each at base+0 to base+3.
`define APU_CH1_BASE 8'h11
`define APU_CH2_BASE 8'h16
`define APU_CH3_BASE 8'h1B
`define APU_CH4_BASE 8'h20

// NR52 fields.
`define APU_PWR_BIT 7
`define APU_NR52_FILL 3'b111 // unused bits 6 to 4 read high.

// channel base+3 fields.
`define APU_TRIG_BIT 7
`define APU_LEN_EN_BIT 6

// test mode frame tick, in apuv_4mhz cycles.
`define APU_FAST_DIV 16

`endif

// File: apu_control.sv
`timescale 1ns/1ns
`include "apu_consts.svh"

module apu_control
	import apu_pkg::*;
(
	input  logic       apuv_4mhz,
	input  logic       rst_n,
	input  logic [7:0] addr,
	input  logic       wr,
	input  logic [7:0] wdata,
	input  logic       rd,
	input  logic [3:0] ch_active,
	output logic [7:0] rdata,
	output logic       chan_rst_n,
	output logic [7:0] panning,
	output mvol_t      vol_l,
	output mvol_t      vol_r
);

	logic power;
	logic [7:0] nr50;
	logic [7:0] nr51;
	logic wr_nr50;
	logic wr_nr51;
	logic wr_nr52;
	logic pwr_off;

	// only NR52 is writable with power off.
	assign wr_nr52 = wr && (addr == `APU_NR52);
	assign wr_nr50 = wr && power && (addr == `APU_NR50);
	assign wr_nr51 = wr && power && (addr == `APU_NR51);
	assign pwr_off = wr_nr52 && !wdata[`APU_PWR_BIT];

	always_ff @(posedge apuv_4mhz) begin
		if (!rst_n) begin
			power <= 1'b0;
		end else if (wr_nr52) begin
			power <= wdata[`APU_PWR_BIT];
		end
	end

	// master volume, bits 7 and 3 are the external input enables.
	always_ff @(posedge apuv_4mhz) begin
		if (!rst_n || pwr_off) begin
			nr50 <= '0;
		end else if (wr_nr50) begin
			nr50 <= wdata;
		end
	end

	always_ff @(posedge apuv_4mhz) begin
		if (!rst_n || pwr_off) begin
			nr51 <= '0;
		end else if (wr_nr51) begin
			nr51 <= wdata;
		end
	end

	// power off holds the channels and mixer in reset.
	assign chan_rst_n = rst_n && power;

	assign panning = nr51;
	assign vol_l   = nr50[6:4];
	assign vol_r   = nr50[2:0];

	// registered readback.
	always_ff @(posedge apuv_4mhz) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (rd) begin
			case (addr)
				`APU_NR50: rdata <= nr50;
				`APU_NR51: rdata <= nr51;
				`APU_NR52: rdata <= {power, `APU_NR52_FILL, ch_active};
				default:   rdata <= '0;
			endcase
		end else begin
			rdata <= '0;
		end
	end

endmodule

// File: apu_mixer.sv
`timescale 1ns/1ns

module apu_mixer
	import apu_pkg::*;
(
	input  logic       apuv_4mhz,
	input  logic       chan_rst_n,
	input  level_t     lvl1,
	input  level_t     lvl2,
	input  level_t     lvl3,
	input  level_t     lvl4,
	input  logic [7:0] panning,
	input  mvol_t      vol_l,
	input  mvol_t      vol_r,
	output mix_t       mix_l,
	output mix_t       mix_r
);

	// sel[0] picks channel 1, sel[3] channel 4.
	function automatic mix_t side_mix(
		input logic [3:0] sel,
		input level_t     l1,
		input level_t     l2,
		input level_t     l3,
		input level_t     l4,
		input mvol_t      vol
	);
		logic [5:0] sum;
		logic [3:0] gain;
		logic [9:0] prod;
		sum = '0;
		if (sel[0]) sum = sum + 6'(l1);
		if (sel[1]) sum = sum + 6'(l2);
		if (sel[2]) sum = sum + 6'(l3);
		if (sel[3]) sum = sum + 6'(l4);
		gain = 4'(vol) + 4'd1; // 1 to 8.
		prod = 10'(sum) * 10'(gain);
		return mix_t'(prod);
	endfunction

	mix_t next_l;
	mix_t next_r;

	assign next_l = side_mix(panning[7:4], lvl1, lvl2, lvl3, lvl4, vol_l);
	assign next_r = side_mix(panning[3:0], lvl1, lvl2, lvl3, lvl4, vol_r);

	// one cycle output lag.
	always_ff @(posedge apuv_4mhz) begin
		if (!chan_rst_n) begin
			mix_l <= '0;
			mix_r <= '0;
		end else begin
			mix_l <= next_l;
			mix_r <= next_r;
		end
	end

endmodule

// File: apu_pkg.sv
package apu_pkg;

	// channel output level, 0 to 15.
	typedef logic [3:0] level_t;

	// master volume per side, gain is value + 1.
	typedef logic [2:0] mvol_t;

	// scaled side output, 4 * 15 * 8 = 480 at most.
	typedef logic [8:0] mix_t;

	// frame sequencer step number.
	typedef logic [2:0] step_t;

endpackage

// File: apu_tone_chan.sv
`timescale 1ns/1ns
`include "apu_consts.svh"

module apu_tone_chan
	import apu_pkg::*;
#(
	parameter logic [7:0] BASE     = `APU_CH1_BASE,
	parameter int         LEN_BITS = 6
)(
	input  logic       apuv_4mhz,
	input  logic       chan_rst_n,
	input  logic [7:0] addr,
	input  logic       wr,
	input  logic [7:0] wdata,
	input  logic       en_1mhz,
	input  logic       len_tick,
	output level_t     level,
	output logic       active
);

	logic sel_len;
	logic sel_vol;
	logic sel_per;
	logic sel_ctl;
	logic trigger;
	logic [LEN_BITS-1:0] len_load;
	logic [LEN_BITS-1:0] len_cnt;
	level_t vol;
	logic [7:0] period;
	logic [7:0] div_cnt;
	logic len_en;
	logic phase;

	assign sel_len = wr && (addr == BASE);
	assign sel_vol = wr && (addr == BASE + 8'd1);
	assign sel_per = wr && (addr == BASE + 8'd2);
	assign sel_ctl = wr && (addr == BASE + 8'd3);
	assign trigger = sel_ctl && wdata[`APU_TRIG_BIT];

	always_ff @(posedge apuv_4mhz) begin
		if (!chan_rst_n) begin
			len_load <= '0;
			vol      <= '0;
			period   <= '0;
			len_en   <= 1'b0;
		end else begin
			if (sel_len) len_load <= wdata[LEN_BITS-1:0];
			if (sel_vol) vol <= wdata[7:4];
			if (sel_per) period <= wdata;
			if (sel_ctl) len_en <= wdata[`APU_LEN_EN_BIT];
		end
	end

	// length counts up, wrap ends the note.
	always_ff @(posedge apuv_4mhz) begin
		if (!chan_rst_n) begin
			active  <= 1'b0;
			len_cnt <= '0;
		end else if (trigger) begin
			active  <= (vol != '0); // silent volume never starts.
			len_cnt <= len_load;
		end else if (active && len_en && len_tick) begin
			len_cnt <= len_cnt + LEN_BITS'(1);
			if (len_cnt == '1) begin
				active <= 1'b0;
			end
		end
	end

	// square wave, phase flips every period+1 enables.
	always_ff @(posedge apuv_4mhz) begin
		if (!chan_rst_n) begin
			div_cnt <= '0;
			phase   <= 1'b0;
		end else if (trigger) begin
			div_cnt <= '0;
			phase   <= 1'b1; // start on the high half.
		end else if (en_1mhz) begin
			if (div_cnt == period) begin
				div_cnt <= '0;
				phase   <= !phase;
			end else begin
				div_cnt <= div_cnt + 8'd1;
			end
		end
	end

	assign level = (active && phase) ? vol : '0;

endmodule

// File: apu_top.sv
`timescale 1ns/1ns
`include "apu_consts.svh"

module apu_top
	import apu_pkg::*;
(
	input  logic       apuv_4mhz,
	input  logic       rst_n,
	input  logic [7:0] addr,
	input  logic       wr,
	input  logic [7:0] wdata,
	input  logic       rd,
	output logic [7:0] rdata,
	input  logic       frame_tick,
	input  logic       test_mode,
	output mix_t       mix_l,
	output mix_t       mix_r,
	output logic [3:0] ch_active
);

	logic en_1mhz;
	logic len_tick;
	logic chan_rst_n;
	logic [7:0] panning;
	mvol_t vol_l;
	mvol_t vol_r;
	level_t lvl1;
	level_t lvl2;
	level_t lvl3;
	level_t lvl4;

	// 2 MHz and step number have no user without sweep and envelope.
	apu_clock_gen clk_gen_i (
		.apuv_4mhz  (apuv_4mhz),
		.rst_n      (rst_n),
		.frame_tick (frame_tick),
		.test_mode  (test_mode),
		.en_2mhz    (),
		.en_1mhz    (en_1mhz),
		.len_tick   (len_tick),
		.frame_step ()
	);

	apu_control ctrl_i (
		.apuv_4mhz  (apuv_4mhz),
		.rst_n      (rst_n),
		.addr       (addr),
		.wr         (wr),
		.wdata      (wdata),
		.rd         (rd),
		.ch_active  (ch_active),
		.rdata      (rdata),
		.chan_rst_n (chan_rst_n),
		.panning    (panning),
		.vol_l      (vol_l),
		.vol_r      (vol_r)
	);

	apu_tone_chan #(.BASE(`APU_CH1_BASE), .LEN_BITS(6)) ch1_i (
		.apuv_4mhz (apuv_4mhz), .chan_rst_n (chan_rst_n),
		.addr (addr), .wr (wr), .wdata (wdata),
		.en_1mhz (en_1mhz), .len_tick (len_tick),
		.level (lvl1), .active (ch_active[0])
	);

	apu_tone_chan #(.BASE(`APU_CH2_BASE), .LEN_BITS(6)) ch2_i (
		.apuv_4mhz (apuv_4mhz), .chan_rst_n (chan_rst_n),
		.addr (addr), .wr (wr), .wdata (wdata),
		.en_1mhz (en_1mhz), .len_tick (len_tick),
		.level (lvl2), .active (ch_active[1])
	);

	apu_tone_chan #(.BASE(`APU_CH3_BASE), .LEN_BITS(8)) ch3_i (
		.apuv_4mhz (apuv_4mhz), .chan_rst_n (chan_rst_n),
		.addr (addr), .wr (wr), .wdata (wdata),
		.en_1mhz (en_1mhz), .len_tick (len_tick),
		.level (lvl3), .active (ch_active[2])
	);

	apu_tone_chan #(.BASE(`APU_CH4_BASE), .LEN_BITS(6)) ch4_i (
		.apuv_4mhz (apuv_4mhz), .chan_rst_n (chan_rst_n),
		.addr (addr), .wr (wr), .wdata (wdata),
		.en_1mhz (en_1mhz), .len_tick (len_tick),
		.level (lvl4), .active (ch_active[3])
	);

	apu_mixer mixer_i (
		.apuv_4mhz  (apuv_4mhz),
		.chan_rst_n (chan_rst_n),
		.lvl1       (lvl1),
		.lvl2       (lvl2),
		.lvl3       (lvl3),
		.lvl4       (lvl4),
		.panning    (panning),
		.vol_l      (vol_l),
		.vol_r      (vol_r),
		.mix_l      (mix_l),
		.mix_r      (mix_r)
	);

endmodule

// File: tb_apu.sv
`timescale 1ns/1ns
`include "apu_consts.svh"

module tb_apu;
	import apu_pkg::*;

	localparam int TICK_CYC = `APU_FAST_DIV * 2; // len_tick every other frame step.
	localparam int WATCHDOG_NS = ((64 + 256) * TICK_CYC + 1500) * 20;

	logic apuv_4mhz;
	logic rst_n;
	logic [7:0] addr;
	logic wr;
	logic [7:0] wdata;
	logic rd;
	logic [7:0] rdata;
	logic frame_tick;
	logic test_mode;
	mix_t mix_l;
	mix_t mix_r;
	logic [3:0] ch_active;

	integer seed = 88;
	int cyc = 0;
	int errors = 0;
	int err_mark = 0;
	int passed = 0;
	int failed = 0;
	logic [7:0] d;
	logic [7:0] r50;
	logic [7:0] r51;
	logic [7:0] len;
	logic [7:0] bases [4];
	int vols [4];
	int v;
	int high;
	int el;
	int er;
	int saw_zero;
	int saw_high;
	int bad_l;
	int bad_r;

	apu_top dut_i (
		.apuv_4mhz  (apuv_4mhz),
		.rst_n      (rst_n),
		.addr       (addr),
		.wr         (wr),
		.wdata      (wdata),
		.rd         (rd),
		.rdata      (rdata),
		.frame_tick (frame_tick),
		.test_mode  (test_mode),
		.mix_l      (mix_l),
		.mix_r      (mix_r),
		.ch_active  (ch_active)
	);

	always #10 apuv_4mhz = ~apuv_4mhz;
	always @(posedge apuv_4mhz) cyc <= cyc + 1;

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic check_equal(input string name, input int exp, input int act);
		assert (exp == act) else begin
			$display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input string what, input bit cond);
		assert (cond) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (errors == err_mark) begin
			passed++;
			$display("test %s passed", name);
		end else begin
			failed++;
			$display("test %s failed with %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	// all tasks start and end 2 ns after a rising edge.
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge apuv_4mhz);
			#2;
		end
	endtask

	task automatic reg_write(input logic [7:0] a, input logic [7:0] data);
		addr  = a;
		wdata = data;
		wr    = 1'b1;
		wait_cycles(1);
		wr    = 1'b0;
	endtask

	task automatic reg_read(input logic [7:0] a, output logic [7:0] data);
		addr = a;
		rd   = 1'b1;
		wait_cycles(1);
		data = rdata; // registered on the edge just passed.
		rd   = 1'b0;
	endtask

	task automatic chan_write(input logic [7:0] base, input logic [7:0] l,
		input logic [7:0] vol, input logic [7:0] per, input logic [7:0] ctl);
		reg_write(base, l);
		reg_write(base + 8'd1, vol);
		reg_write(base + 8'd2, per);
		reg_write(base + 8'd3, ctl);
	endtask

	// trigger with length on, then time the clear in len_tick periods.
	task automatic length_test(input string name, input logic [7:0] base, input int idx,
		input int span, input logic [7:0] l);
		int n;
		int t0;
		int k;
		int c;
		logic [7:0] rb;
		n = span - int'(l);
		chan_write(base, l, 8'hA0, 8'h10, 8'hC0);
		t0 = cyc;
		reg_read(`APU_NR52, rb);
		check_equal({name, " nr52 active"}, 'hF0 | (1 << idx), int'(rb));
		k = 0;
		while (ch_active[idx] && k < n * TICK_CYC + 64) begin
			wait_cycles(1);
			k++;
		end
		if (ch_active[idx]) begin
			check_true({name, ": channel never went inactive"}, 1'b0);
		end else begin
			c = cyc - t0;
			check_true($sformatf("Mismatch %s: expected clear after %0d to %0d cycles, actual %0d",
				name, (n - 1) * TICK_CYC + 1, n * TICK_CYC, c),
				c > (n - 1) * TICK_CYC && c <= n * TICK_CYC);
		end
		reg_read(`APU_NR52, rb);
		check_equal({name, " nr52 cleared"}, 'hF0, int'(rb));
		end_test(name);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		apuv_4mhz  = 1'b0;
		rst_n      = 1'b0;
		addr       = '0;
		wr         = 1'b0;
		wdata      = '0;
		rd         = 1'b0;
		frame_tick = 1'b0;
		test_mode  = 1'b1;
		bases[0] = `APU_CH1_BASE;
		bases[1] = `APU_CH2_BASE;
		bases[2] = `APU_CH3_BASE;
		bases[3] = `APU_CH4_BASE;
		repeat (4) @(posedge apuv_4mhz);
		#2 rst_n = 1'b1;
		wait_cycles(1);

		reg_read(`APU_NR52, d);
		check_equal("reset_state nr52", 'h70, int'(d));
		check_equal("reset_state mix_l", 0, int'(mix_l));
		check_equal("reset_state mix_r", 0, int'(mix_r));
		reg_write(`APU_NR50, rand_byte()); // power off, must be dropped.
		reg_read(`APU_NR50, d);
		check_equal("reset_state nr50", 0, int'(d));
		end_test("reset_state");

		reg_write(`APU_NR52, 8'h80);
		r50 = rand_byte();
		r51 = rand_byte();
		reg_write(`APU_NR50, r50);
		reg_write(`APU_NR51, r51);
		reg_read(`APU_NR50, d);
		check_equal("master_regs nr50", int'(r50), int'(d));
		reg_read(`APU_NR51, d);
		check_equal("master_regs nr51", int'(r51), int'(d));
		end_test("master_regs");

		len = rand_byte() & 8'h1F;
		length_test("length_ch1", `APU_CH1_BASE, 0, 64, len);
		len = rand_byte() & 8'h7F;
		length_test("length_ch3", `APU_CH3_BASE, 2, 256, len);

		// channel 2 alone on the left.
		v = int'(rand_byte() % 8'd15) + 1;
		r50 = rand_byte();
		high = v * (int'(r50[6:4]) + 1);
		reg_write(`APU_NR50, r50);
		reg_write(`APU_NR51, 8'h20);
		chan_write(`APU_CH2_BASE, 8'h00, 8'(v << 4), 8'd2, 8'h80);
		wait_cycles(4);
		saw_zero = 0;
		saw_high = 0;
		bad_l = 0;
		bad_r = 0;
		repeat (96) begin
			if (mix_l == '0) saw_zero++;
			else if (int'(mix_l) == high) saw_high++;
			else bad_l++;
			if (mix_r != '0) bad_r++;
			wait_cycles(1);
		end
		check_equal("pan_left stray mix_l samples", 0, bad_l);
		check_equal("pan_left nonzero mix_r samples", 0, bad_r);
		check_true("pan_left: mix_l did not show both the silent and the high level",
			saw_zero > 0 && saw_high > 0);
		end_test("pan_left");

		// max period keeps all phases high long after the triggers.
		r50 = rand_byte();
		r51 = rand_byte() | 8'h11;
		reg_write(`APU_NR50, r50);
		reg_write(`APU_NR51, r51);
		el = 0;
		er = 0;
		for (int i = 0; i < 4; i++) begin
			vols[i] = int'(rand_byte() % 8'd15) + 1;
			chan_write(bases[i], 8'h00, 8'(vols[i] << 4), 8'hFF, 8'h00);
			el = el + (r51[4 + i] ? vols[i] : 0);
			er = er + (r51[i] ? vols[i] : 0);
		end
		for (int i = 0; i < 4; i++) reg_write(bases[i] + 8'd3, 8'h80);
		wait_cycles(3);
		check_equal("mix_all ch_active", 15, int'(ch_active));
		check_equal("mix_all mix_l", el * (int'(r50[6:4]) + 1), int'(mix_l));
		check_equal("mix_all mix_r", er * (int'(r50[2:0]) + 1), int'(mix_r));
		end_test("mix_all");

		reg_write(`APU_NR52, 8'h00);
		wait_cycles(2);
		check_equal("power_off mix_l", 0, int'(mix_l));
		check_equal("power_off mix_r", 0, int'(mix_r));
		check_equal("power_off ch_active", 0, int'(ch_active));
		reg_read(`APU_NR50, d);
		check_equal("power_off nr50", 0, int'(d));
		reg_read(`APU_NR51, d);
		check_equal("power_off nr51", 0, int'(d));
		reg_read(`APU_NR52, d);
		check_equal("power_off nr52", 'h70, int'(d));
		chan_write(`APU_CH1_BASE, 8'h00, 8'hF0, 8'h01, 8'hC0);
		wait_cycles(2);
		check_equal("power_off trigger ch_active", 0, int'(ch_active));
		end_test("power_off");

		$display("tests passed %0d, failed %0d, check errors %0d", passed, failed, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
